// ==== gb_pkg.sv ====
`default_nettype none

package gb_pkg;

  // --------------------------------------------------------------------
  // memory map
  // --------------------------------------------------------------------
  localparam logic [15:0] ADDR_IF  = 16'hFF0F;
  localparam logic [15:0] ADDR_IE  = 16'hFFFF;
  localparam logic [15:0] ADDR_SB  = 16'hFF01;
  localparam logic [15:0] VEC_BASE = 16'h0040;

  // vblank, stat, timer, serial, joypad
  localparam int INT_COUNT = 5;

  // --------------------------------------------------------------------
  // bus and io requests
  // --------------------------------------------------------------------
  typedef struct packed {
    logic [15:0] addr;
    logic        we;
    logic [7:0]  wdata;
  } mem_req_t;

  // ie/if access forwarded by the memory decoder
  typedef struct packed {
    logic       sel_ie;
    logic       sel_if;
    logic       we;
    logic [7:0] wdata;
  } io_req_t;

  // --------------------------------------------------------------------
  // cpu and alu types
  // --------------------------------------------------------------------
  typedef enum logic [3:0] {
    FETCH,
    DECODE,
    ARG_LO,
    ARG_HI,
    MEM_RD,
    MEM_WR,
    PUSH_HI,
    PUSH_LO,
    POP_LO,
    POP_HI,
    HALT,
    INT_ENTRY
  } cpu_state_t;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    XOR,
    OR,
    CP,
    INC,
    DEC
  } alu_op_t;

  // same order as the upper nibble of F
  typedef struct packed {
    logic z;
    logic n;
    logic h;
    logic c;
  } alu_flags_t;

endpackage

`default_nettype wire

// ==== gb_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_alu
  import gb_pkg::*;
(
  input  alu_op_t    op,
  input  logic [7:0] a,
  input  logic [7:0] b,
  input  alu_flags_t cin_flags,
  output logic [7:0] y,
  output alu_flags_t flags
);

  logic [8:0] sum;
  logic [8:0] diff;
  logic [4:0] sum_lo;
  logic [4:0] diff_lo;

  // carry and borrow out of bit 7 and bit 3
  assign sum     = {1'b0, a} + {1'b0, b};
  assign diff    = {1'b0, a} - {1'b0, b};
  assign sum_lo  = {1'b0, a[3:0]} + {1'b0, b[3:0]};
  assign diff_lo = {1'b0, a[3:0]} - {1'b0, b[3:0]};

  always_comb begin
    y     = a;
    flags = cin_flags;
    case (op)
      ADD: begin
        y       = sum[7:0];
        flags.n = 1'b0;
        flags.h = sum_lo[4];
        flags.c = sum[8];
      end
      SUB, CP: begin
        // cp leaves a untouched
        if (op == SUB) begin
          y = diff[7:0];
        end
        flags.n = 1'b1;
        flags.h = diff_lo[4];
        flags.c = diff[8];
      end
      AND: begin
        y       = a & b;
        flags.n = 1'b0;
        flags.h = 1'b1;
        flags.c = 1'b0;
      end
      XOR, OR: begin
        y       = (op == XOR) ? (a ^ b) : (a | b);
        flags.n = 1'b0;
        flags.h = 1'b0;
        flags.c = 1'b0;
      end
      INC: begin
        y       = a + 8'd1;
        flags.n = 1'b0;
        flags.h = (a[3:0] == 4'hF);
      end
      DEC: begin
        y       = a - 8'd1;
        flags.n = 1'b1;
        flags.h = (a[3:0] == 4'h0);
      end
    endcase
    flags.z = (op == CP) ? (diff[7:0] == 8'h00) : (y == 8'h00);
  end

endmodule

`default_nettype wire

// ==== gb_irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_irq_ctrl
  import gb_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [INT_COUNT-1:0] irq,
  input  io_req_t              io,
  input  logic                 int_ack,
  output logic [7:0]           io_rdata,
  output logic                 pending,
  output logic [2:0]           vec_idx
);

  logic [INT_COUNT-1:0] ie_reg;
  logic [INT_COUNT-1:0] if_reg;
  logic [INT_COUNT-1:0] irq_prev;
  logic [INT_COUNT-1:0] rise;
  logic [INT_COUNT-1:0] active;
  logic [INT_COUNT-1:0] ack_mask;
  logic [INT_COUNT-1:0] if_base;

  assign rise    = irq & ~irq_prev;
  assign active  = ie_reg & if_reg;
  assign pending = |active;

  // lowest numbered line has priority
  always_comb begin
    vec_idx = 3'd0;
    for (int i = INT_COUNT - 1; i >= 0; i--) begin
      if (active[i]) begin
        vec_idx = 3'(i);
      end
    end
  end

  always_comb begin
    ack_mask = '0;
    if (int_ack) begin
      ack_mask[vec_idx] = 1'b1;
    end
    // software write replaces IF, a new edge still gets in
    if (io.sel_if && io.we) begin
      if_base = io.wdata[INT_COUNT-1:0];
    end else begin
      if_base = if_reg & ~ack_mask;
    end
  end

  always_comb begin
    io_rdata = 8'h00;
    if (io.sel_ie) begin
      io_rdata = 8'(ie_reg);
    end else if (io.sel_if) begin
      io_rdata = 8'(if_reg);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ie_reg   <= '0;
      if_reg   <= '0;
      irq_prev <= '0;
    end else begin
      irq_prev <= irq;
      if_reg   <= if_base | rise;
      if (io.sel_ie && io.we) begin
        ie_reg <= io.wdata[INT_COUNT-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== gb_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_mem
  import gb_pkg::*;
#(
  parameter int MEM_WORDS = 4096
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       req,
  input  mem_req_t   mreq,
  input  logic [7:0] io_rdata,
  output logic       ack,
  output logic [7:0] rdata,
  output io_req_t    io,
  output logic       serial_valid,
  output logic [7:0] serial_data
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [7:0]    ram [0:MEM_WORDS-1];
  logic [AW-1:0] ram_addr;
  logic          start;
  logic          sel_ie;
  logic          sel_if;
  logic          sel_sb;
  logic          sel_io;

  initial begin
    $readmemh("program.hex", ram);
  end

  // first cycle of an access, ack rises at the next edge
  assign start    = req && !ack;
  assign sel_ie   = (mreq.addr == ADDR_IE);
  assign sel_if   = (mreq.addr == ADDR_IF);
  assign sel_sb   = (mreq.addr == ADDR_SB);
  assign sel_io   = sel_ie || sel_if;
  assign ram_addr = mreq.addr[AW-1:0];

  assign io.sel_ie = req && sel_ie;
  assign io.sel_if = req && sel_if;
  assign io.we     = start && mreq.we;
  assign io.wdata  = mreq.wdata;

  // ------------------------------------------------------------------
  // four-phase slave
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      ack          <= 1'b0;
      serial_valid <= 1'b0;
    end else begin
      ack          <= req;
      serial_valid <= start && mreq.we && sel_sb;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      if (sel_io) begin
        rdata <= io_rdata;
      end else if (sel_sb) begin
        rdata <= serial_data;
      end else begin
        rdata <= ram[ram_addr];
      end
      if (mreq.we && sel_sb) begin
        serial_data <= mreq.wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && mreq.we && !sel_io && !sel_sb) begin
      ram[ram_addr] <= mreq.wdata;
    end
  end

endmodule

`default_nettype wire

// ==== gb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_cpu
  import gb_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       ack,
  input  logic [7:0] rdata,
  input  logic       pending,
  input  logic [2:0] vec_idx,
  output logic       req,
  output mem_req_t   mreq,
  output logic       int_ack,
  output logic       halted
);

  localparam logic [7:0] OP_HALT  = 8'h76;
  localparam logic [7:0] OP_JP    = 8'hC3;
  localparam logic [7:0] OP_RETI  = 8'hD9;
  localparam logic [7:0] OP_JP_HL = 8'hE9;
  localparam logic [7:0] OP_LD_NN = 8'hEA;
  localparam logic [7:0] OP_DI    = 8'hF3;
  localparam logic [7:0] OP_EI    = 8'hFB;

  // indexed as in the opcode, b c d e h l (hl) a
  // slot 6 is (hl) and is never written
  logic [7:0]  regs [0:7];
  alu_flags_t  f;
  logic [15:0] sp;
  logic [15:0] pc;
  logic        ime;

  cpu_state_t  state;
  logic [7:0]  op;
  logic [7:0]  arg_lo;
  logic [7:0]  arg_hi;
  logic [2:0]  vec_num;
  logic [15:0] hl;

  logic [1:0]  quad;
  logic [2:0]  row;
  logic [2:0]  col;
  logic        is_ld_d8;
  logic        is_ld_d16;
  logic        is_incdec;
  logic        is_alu;
  logic        needs_arg;

  alu_op_t     alu_op;
  logic [7:0]  alu_a;
  logic [7:0]  alu_y;
  alu_flags_t  alu_flags;

  mem_req_t    next_req;
  logic        bus_state;
  logic        bus_idle;
  logic        bus_done;
  logic        take_int;

  // ------------------------------------------------------------------
  // decode
  // ------------------------------------------------------------------
  assign quad = op[7:6];
  assign row  = op[5:3];
  assign col  = op[2:0];
  assign hl   = {regs[4], regs[5]};

  assign is_ld_d8  = (quad == 2'd0) && (col == 3'd6) && (row != 3'd6);
  assign is_ld_d16 = (quad == 2'd0) && (col == 3'd1) && !row[0];
  assign is_incdec = (quad == 2'd0) && (col[2:1] == 2'b10) && (row != 3'd6);
  // adc and sbc are not part of the subset
  assign is_alu    = (quad == 2'd2) && (col != 3'd6) && (row != 3'd1) && (row != 3'd3);
  assign needs_arg = is_ld_d8 || is_ld_d16 || (op == OP_JP) || (op == OP_LD_NN);

  always_comb begin
    alu_a = regs[7];
    case (row)
      3'd0:    alu_op = ADD;
      3'd2:    alu_op = SUB;
      3'd4:    alu_op = AND;
      3'd5:    alu_op = XOR;
      3'd6:    alu_op = OR;
      default: alu_op = CP;
    endcase
    if (quad == 2'd0) begin
      alu_a  = regs[row];
      alu_op = col[0] ? DEC : INC;
    end
  end

  gb_alu u_alu (
    .op        (alu_op),
    .a         (alu_a),
    .b         (regs[col]),
    .cin_flags (f),
    .y         (alu_y),
    .flags     (alu_flags)
  );

  // ------------------------------------------------------------------
  // bus master
  // ------------------------------------------------------------------
  assign bus_state = !(state inside {DECODE, HALT, INT_ENTRY});
  assign bus_idle  = !req && !ack;
  assign bus_done  = req && ack;
  assign take_int  = (state == FETCH) && bus_idle && ime && pending;

  always_comb begin
    next_req.addr  = pc;
    next_req.we    = 1'b0;
    next_req.wdata = 8'h00;
    case (state)
      MEM_RD: next_req.addr = hl;
      MEM_WR: begin
        next_req.addr  = (op == OP_LD_NN) ? {arg_hi, arg_lo} : hl;
        next_req.we    = 1'b1;
        next_req.wdata = (op == OP_LD_NN) ? regs[7] : regs[col];
      end
      PUSH_HI, PUSH_LO: begin
        next_req.addr  = sp;
        next_req.we    = 1'b1;
        next_req.wdata = (state == PUSH_HI) ? pc[15:8] : pc[7:0];
      end
      POP_LO, POP_HI: next_req.addr = sp;
      default: ;
    endcase
  end

  // ------------------------------------------------------------------
  // main state machine
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= FETCH;
      req     <= 1'b0;
      int_ack <= 1'b0;
      halted  <= 1'b0;
      pc      <= 16'h0000;
      sp      <= 16'hFFFE;
      ime     <= 1'b0;
    end else begin
      int_ack <= 1'b0;
      if (bus_state && bus_idle && !take_int) begin
        req  <= 1'b1;
        mreq <= next_req;
      end
      if (bus_done) begin
        req <= 1'b0;
      end
      case (state)
        FETCH: begin
          if (take_int) begin
            int_ack <= 1'b1;
            ime     <= 1'b0;
            state   <= INT_ENTRY;
          end else if (bus_done) begin
            op    <= rdata;
            pc    <= pc + 16'd1;
            state <= DECODE;
          end
        end
        DECODE: begin
          state <= FETCH;
          if (needs_arg) begin
            state <= ARG_LO;
          end else if (op == OP_HALT) begin
            halted <= 1'b1;
            state  <= HALT;
          end else if (quad == 2'd1) begin
            if (col == 3'd6) begin
              state <= MEM_RD;
            end else if (row == 3'd6) begin
              state <= MEM_WR;
            end else begin
              regs[row] <= regs[col];
            end
          end else if (is_incdec) begin
            regs[row] <= alu_y;
            f         <= alu_flags;
          end else if (is_alu) begin
            // cp hands a back unchanged
            regs[7] <= alu_y;
            f       <= alu_flags;
          end else if (op == OP_JP_HL) begin
            pc <= hl;
          end else if (op == OP_DI) begin
            ime <= 1'b0;
          end else if (op == OP_EI) begin
            ime <= 1'b1;
          end else if (op == OP_RETI) begin
            state <= POP_LO;
          end
        end
        ARG_LO: begin
          if (bus_done) begin
            arg_lo <= rdata;
            pc     <= pc + 16'd1;
            if (is_ld_d8) begin
              regs[row] <= rdata;
              state     <= FETCH;
            end else begin
              state <= ARG_HI;
            end
          end
        end
        ARG_HI: begin
          if (bus_done) begin
            arg_hi <= rdata;
            pc     <= pc + 16'd1;
            state  <= FETCH;
            if (op == OP_JP) begin
              pc <= {rdata, arg_lo};
            end else if (op == OP_LD_NN) begin
              state <= MEM_WR;
            end else if (row[2:1] == 2'd3) begin
              sp <= {rdata, arg_lo};
            end else begin
              regs[{row[2:1], 1'b0}] <= rdata;
              regs[{row[2:1], 1'b1}] <= arg_lo;
            end
          end
        end
        MEM_RD: begin
          if (bus_done) begin
            regs[row] <= rdata;
            state     <= FETCH;
          end
        end
        MEM_WR: begin
          if (bus_done) begin
            state <= FETCH;
          end
        end
        INT_ENTRY: begin
          // int_ack is high now, so vec_idx names the cleared line
          vec_num <= vec_idx;
          sp      <= sp - 16'd1;
          state   <= PUSH_HI;
        end
        PUSH_HI: begin
          if (bus_done) begin
            sp    <= sp - 16'd1;
            state <= PUSH_LO;
          end
        end
        PUSH_LO: begin
          if (bus_done) begin
            pc    <= VEC_BASE + {10'd0, vec_num, 3'b000};
            state <= FETCH;
          end
        end
        POP_LO: begin
          if (bus_done) begin
            arg_lo <= rdata;
            sp     <= sp + 16'd1;
            state  <= POP_HI;
          end
        end
        POP_HI: begin
          if (bus_done) begin
            pc    <= {rdata, arg_lo};
            sp    <= sp + 16'd1;
            ime   <= 1'b1;
            state <= FETCH;
          end
        end
        HALT: begin
          // wake on any pending line, fetch takes it if ime is set
          if (pending) begin
            halted <= 1'b0;
            state  <= FETCH;
          end
        end
        default: state <= FETCH;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== gb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_top
  import gb_pkg::*;
#(
  parameter int MEM_WORDS = 4096
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [INT_COUNT-1:0] irq,
  output logic                 serial_valid,
  output logic [7:0]           serial_data,
  output logic                 halted
);

  // cpu to memory bus
  logic       req;
  logic       ack;
  mem_req_t   mreq;
  logic [7:0] rdata;

  // memory to interrupt controller
  io_req_t    io;
  logic [7:0] io_rdata;

  // interrupt controller to cpu
  logic       pending;
  logic [2:0] vec_idx;
  logic       int_ack;

  gb_cpu u_cpu (
    .clk     (clk),
    .rst     (rst),
    .ack     (ack),
    .rdata   (rdata),
    .pending (pending),
    .vec_idx (vec_idx),
    .req     (req),
    .mreq    (mreq),
    .int_ack (int_ack),
    .halted  (halted)
  );

  gb_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .mreq         (mreq),
    .io_rdata     (io_rdata),
    .ack          (ack),
    .rdata        (rdata),
    .io           (io),
    .serial_valid (serial_valid),
    .serial_data  (serial_data)
  );

  gb_irq_ctrl u_irq (
    .clk      (clk),
    .rst      (rst),
    .irq      (irq),
    .io       (io),
    .int_ack  (int_ack),
    .io_rdata (io_rdata),
    .pending  (pending),
    .vec_idx  (vec_idx)
  );

endmodule

`default_nettype wire

// ==== tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top
  import gb_pkg::*;
;

  localparam int          RESET_CYCLES    = 5;
  localparam int          RUN_TIMEOUT     = 5000;
  localparam int          WAKE_TIMEOUT    = 50;
  localparam int          HANDLER_TIMEOUT = 800;
  localparam int          QUIET_CYCLES    = 200;
  localparam int          WAKE_ROUNDS     = 4;
  localparam int          PRIO_ROUNDS     = 3;
  localparam logic [31:0] LFSR_SEED       = 32'hee711ad2;
  localparam logic [31:0] LFSR_TAPS       = 32'h80200003;

  // constants baked into program.hex
  localparam logic [7:0] OPA          = 8'h3C;
  localparam logic [7:0] OPB          = 8'h5A;
  localparam logic [7:0] STORE_VAL    = 8'hA5;
  localparam logic [7:0] MARK_JP_HL   = 8'h4A;
  localparam logic [7:0] MARK_JP      = 8'h4B;
  localparam logic [7:0] HANDLER_BASE = 8'h30;

  logic                 clk = 1'b0;
  logic                 rst;
  logic [INT_COUNT-1:0] irq;
  logic                 serial_valid;
  logic [7:0]           serial_data;
  logic                 halted;

  logic [7:0]           expected [$];
  logic [7:0]           serial_head;
  logic [31:0]          lfsr;

  gb_top #(
    .MEM_WORDS (4096)
  ) dut (
    .clk          (clk),
    .rst          (rst),
    .irq          (irq),
    .serial_valid (serial_valid),
    .serial_data  (serial_data),
    .halted       (halted)
  );

  always #50 clk = ~clk;

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end else begin
      return s >> 1;
    end
  endfunction

  // one lfsr step per bit
  function automatic logic [7:0] take_bits(input int count);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < count; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic want);
    assert (got === want) else begin
      fail_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, want));
    end
  endtask

  task automatic wait_halted(input logic level, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (halted !== level && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (halted !== level) begin
      fail_run($sformatf("timeout after %0d cycles waiting for %s", limit, what));
    end
  endtask

  task automatic wait_drain(input int limit, input string what);
    int cycles;
    cycles = 0;
    while (expected.size() != 0 && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (expected.size() != 0) begin
      fail_run($sformatf("timeout after %0d cycles, %0d of %s never arrived",
                         limit, expected.size(), what));
    end
  endtask

  // one-cycle pulse on the given lines, handler bytes come in line order
  task automatic raise_lines(input logic [INT_COUNT-1:0] lines);
    for (int i = 0; i < INT_COUNT; i++) begin
      if (lines[i]) begin
        expected.push_back(HANDLER_BASE + 8'(i));
      end
    end
    check_bit("halted", halted, 1'b1);
    irq <= lines;
    @(posedge clk);
    irq <= '0;
    wait_halted(1'b0, WAKE_TIMEOUT, "halted to fall after an interrupt edge");
    wait_drain(HANDLER_TIMEOUT, "the interrupt handler bytes");
    wait_halted(1'b1, HANDLER_TIMEOUT, "the CPU to return to HALT");
  endtask

  // --------------------------------------------------------------------
  // serial stream checker
  // --------------------------------------------------------------------
  always @(negedge clk) begin
    if (serial_valid === 1'b1) begin
      if (expected.size() == 0) begin
        fail_run($sformatf("unexpected serial byte %02h at %0t", serial_data, $time));
      end else begin
        serial_head = expected.pop_front();
        assert (serial_data === serial_head) else begin
          fail_run($sformatf("MISMATCH at %0t: serial_data is %02h, expected %02h",
                             $time, serial_data, serial_head));
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------
  initial begin
    logic [7:0]           bits;
    logic [INT_COUNT-1:0] lines;
    int                   line;

    rst  = 1'b1;
    irq  = '0;
    lfsr = LFSR_SEED;

    // main program, one store per result
    expected.push_back(OPA + OPB);
    expected.push_back(OPA - OPB);
    expected.push_back(OPA & OPB);
    expected.push_back(OPA ^ OPB);
    expected.push_back(OPA | OPB);
    expected.push_back((OPA | OPB) + 8'd1);
    expected.push_back(OPB - 8'd1);
    expected.push_back(STORE_VAL);
    expected.push_back(MARK_JP_HL);
    expected.push_back(MARK_JP);

    // outputs quiet in and right after reset
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      if (i > 0) begin
        check_bit("halted", halted, 1'b0);
        check_bit("serial_valid", serial_valid, 1'b0);
      end
    end
    rst <= 1'b0;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      check_bit("halted", halted, 1'b0);
      check_bit("serial_valid", serial_valid, 1'b0);
    end

    wait_halted(1'b1, RUN_TIMEOUT, "the CPU to halt after the main program");
    assert (expected.size() == 0) else begin
      fail_run($sformatf("main program halted with %0d serial bytes missing",
                         expected.size()));
    end

    // idle lines, nothing may wake the CPU
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(posedge clk);
      check_bit("halted", halted, 1'b1);
      check_bit("serial_valid", serial_valid, 1'b0);
    end

    for (int r = 0; r < WAKE_ROUNDS; r++) begin
      line        = int'(take_bits(3)) % INT_COUNT;
      lines       = '0;
      lines[line] = 1'b1;
      @(posedge clk);
      raise_lines(lines);
    end

    // several lines on one edge
    for (int r = 0; r < PRIO_ROUNDS; r++) begin
      bits  = take_bits(INT_COUNT);
      lines = bits[INT_COUNT-1:0];
      if ($countones(lines) < 2) begin
        lines = lines | 5'b10001;
      end
      @(posedge clk);
      raise_lines(lines);
    end

    if (expected.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      fail_run("serial bytes still outstanding at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
gb_pkg.sv
gb_alu.sv
gb_irq_ctrl.sv
gb_mem.sv
gb_cpu.sv
gb_top.sv
tb_top.sv

// ==== Makefile ====
# Verilator build and run for the SM83-style CPU subsystem
# override on the command line, e.g. make TOP=tb_top FLAGS="--binary --timing --assert"

TOP        ?= tb_top
RTL_TOP    ?= gb_top
SIM        ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
BUILD_DIR  ?= obj_dir
FILELIST   ?= compile.f

.PHONY: run build lint clean

run: build
	./$(BUILD_DIR)/V$(TOP)

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== program.hex ====
// columns: opcode and operand bytes in address order, one instruction group per line
// @nnnn sets the load address in hex
@0000
C3 80 00                    // jp 0x0080 over the vectors
@0040
3E 30 EA 01 FF D9           // vector 0, ld a,0x30 / ld (sb),a / reti
@0048
3E 31 EA 01 FF D9           // vector 1
@0050
3E 32 EA 01 FF D9           // vector 2
@0058
3E 33 EA 01 FF D9           // vector 3
@0060
3E 34 EA 01 FF D9           // vector 4
@0080
31 00 0E                    // ld sp,0x0e00
3E 3C 06 5A 80 EA 01 FF     // ld a / ld b / add a,b / ld (sb),a
3E 3C 90 EA 01 FF           // sub b
3E 3C A0 EA 01 FF           // and b
3E 3C A8 EA 01 FF           // xor b
3E 3C B0 EA 01 FF           // or b
3C EA 01 FF                 // inc a
05 78 EA 01 FF              // dec b / ld a,b
21 00 0C 3E A5 77           // ld hl,0x0c00 / ld a,0xa5 / ld (hl),a
3E 00 7E EA 01 FF           // clear a / ld a,(hl)
21 C8 00 E9                 // ld hl,0x00c8 / jp hl
3E EE EA 01 FF              // skipped by jp hl
@00C8
3E 4A EA 01 FF C3 E0 00     // marker / jp 0x00e0
3E EF EA 01 FF              // skipped by jp a16
@00E0
3E 4B EA 01 FF              // marker
3E 1F EA FF FF              // ie = 0x1f
FB 76 C3 EB 00              // ei / halt at 0x00eb / jp 0x00eb
